// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_hamster_soc
FILELIST  = compile.f
PASS_MSG  = Simulation completed successfully

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

obj_dir/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim: obj_dir/V$(TOP)
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir

// File: common/hamster_pkg.sv
// Shared widths, address map, GPIO and UART constants
// Enums for decoder targets, arbiter owner and UART FSM states
package hamster_pkg;

  ////////////////////////////////////////////////////////////
  // Bus widths
  ////////////////////////////////////////////////////////////

  // Byte address width
  localparam int unsigned AW = 14;
  // Data and byte enable widths
  localparam int unsigned DW = 32;
  localparam int unsigned BW = DW / 8;
  // Memory word address, 8 KiB in the lower half
  localparam int unsigned MEM_AW = 11;

  ////////////////////////////////////////////////////////////
  // Peripherals
  ////////////////////////////////////////////////////////////

  // GPIO width and register offsets
  localparam int unsigned GW = 32;
  localparam logic [5:0] GPIO_OUT = 6'h00;
  localparam logic [5:0] GPIO_ENA = 6'h04;
  localparam logic [5:0] GPIO_IN = 6'h08;

  // UART register offsets
  localparam logic [5:0] UART_TXD = 6'h00;
  localparam logic [5:0] UART_STS = 6'h04;
  // Clock cycles per serial bit and baud counter width
  localparam int unsigned UART_BDR = 8;
  localparam int unsigned UART_CW = 3;

  ////////////////////////////////////////////////////////////
  // Types
  ////////////////////////////////////////////////////////////

  // Decoder targets
  typedef enum logic [1:0] {
    SEL_MEM,
    SEL_GPIO,
    SEL_UART,
    SEL_ERR
  } tcb_sel_t;

  // Shared bus owner
  typedef enum logic {
    OWN_CPU,
    OWN_DBG
  } arb_own_t;

  // UART transmitter FSM
  typedef enum logic [1:0] {
    IDLE,
    START,
    DATA,
    STOP
  } uart_state_t;

endpackage

// File: common/tcb_if.sv
// TCB bus interface
// Manager and subordinate modports
interface tcb_if (
  input logic clk,
  input logic rst
);

  // Request, driven by the manager
  logic vld;
  logic wen;
  logic [hamster_pkg::AW-1:0] adr;
  logic [hamster_pkg::BW-1:0] ben;
  logic [hamster_pkg::DW-1:0] wdt;

  // Response, one cycle after transfer
  logic [hamster_pkg::DW-1:0] rdt;
  logic err;

  // Back-pressure
  logic rdy;

  modport man (
    input  clk,
    input  rst,
    output vld,
    output wen,
    output adr,
    output ben,
    output wdt,
    input  rdt,
    input  err,
    input  rdy
  );

  modport sub (
    input  clk,
    input  rst,
    input  vld,
    input  wen,
    input  adr,
    input  ben,
    input  wdt,
    output rdt,
    output err,
    output rdy
  );

endinterface

// File: compile.f
common/hamster_pkg.sv
common/tcb_if.sv
tcb/tcb_arb.sv
tcb/tcb_dec.sv
logic/soc_mem.sv
logic/tcb_gpio.sv
logic/tcb_uart_tx.sv
logic/hamster_soc_top.sv
test/tb_checker.sv
test/tb_hamster_soc.sv

// File: logic/hamster_soc_top.sv
// Bus subsystem top, two managers on a shared TCB bus
// Arbiter, decoder, data memory, GPIO and UART transmitter
module hamster_soc_top (
  input  logic                         clk,
  input  logic                         rst,
  // Processor port
  input  logic                         cpu_vld,
  input  logic                         cpu_wen,
  input  logic [hamster_pkg::AW-1:0]   cpu_adr,
  input  logic [hamster_pkg::BW-1:0]   cpu_ben,
  input  logic [hamster_pkg::DW-1:0]   cpu_wdt,
  output logic [hamster_pkg::DW-1:0]   cpu_rdt,
  output logic                         cpu_err,
  output logic                         cpu_rdy,
  // Debug access port
  input  logic                         dbg_vld,
  input  logic                         dbg_wen,
  input  logic [hamster_pkg::AW-1:0]   dbg_adr,
  input  logic [hamster_pkg::BW-1:0]   dbg_ben,
  input  logic [hamster_pkg::DW-1:0]   dbg_wdt,
  output logic [hamster_pkg::DW-1:0]   dbg_rdt,
  output logic                         dbg_err,
  output logic                         dbg_rdy,
  // GPIO
  output logic [hamster_pkg::GW-1:0]   gpio_o,
  output logic [hamster_pkg::GW-1:0]   gpio_e,
  input  logic [hamster_pkg::GW-1:0]   gpio_i,
  // UART
  output logic                         uart_txd
);

  ////////////////////////////////////////////////////////////
  // Buses
  ////////////////////////////////////////////////////////////

  tcb_if bus_cpu  (.clk (clk), .rst (rst));
  tcb_if bus_dbg  (.clk (clk), .rst (rst));
  tcb_if bus_sys  (.clk (clk), .rst (rst));
  tcb_if bus_mem  (.clk (clk), .rst (rst));
  tcb_if bus_gpio (.clk (clk), .rst (rst));
  tcb_if bus_uart (.clk (clk), .rst (rst));

  // Processor port onto its bus
  assign bus_cpu.vld = cpu_vld;
  assign bus_cpu.wen = cpu_wen;
  assign bus_cpu.adr = cpu_adr;
  assign bus_cpu.ben = cpu_ben;
  assign bus_cpu.wdt = cpu_wdt;
  assign cpu_rdt = bus_cpu.rdt;
  assign cpu_err = bus_cpu.err;
  assign cpu_rdy = bus_cpu.rdy;

  // Debug port onto its bus
  assign bus_dbg.vld = dbg_vld;
  assign bus_dbg.wen = dbg_wen;
  assign bus_dbg.adr = dbg_adr;
  assign bus_dbg.ben = dbg_ben;
  assign bus_dbg.wdt = dbg_wdt;
  assign dbg_rdt = bus_dbg.rdt;
  assign dbg_err = bus_dbg.err;
  assign dbg_rdy = bus_dbg.rdy;

  ////////////////////////////////////////////////////////////
  // Interconnect and subordinates
  ////////////////////////////////////////////////////////////

  tcb_arb arb (
    .bus_cpu (bus_cpu),
    .bus_dbg (bus_dbg),
    .bus_sys (bus_sys)
  );

  tcb_dec dec (
    .bus_sys  (bus_sys),
    .bus_mem  (bus_mem),
    .bus_gpio (bus_gpio),
    .bus_uart (bus_uart)
  );

  soc_mem mem (
    .bus (bus_mem)
  );

  tcb_gpio gpio (
    .bus    (bus_gpio),
    .gpio_o (gpio_o),
    .gpio_e (gpio_e),
    .gpio_i (gpio_i)
  );

  tcb_uart_tx uart (
    .bus      (bus_uart),
    .uart_txd (uart_txd)
  );

endmodule

// File: logic/soc_mem.sv
// Single-port data memory on TCB
// Byte enables, one-cycle read
module soc_mem (
  tcb_if.sub bus
);

  // Word storage
  logic [hamster_pkg::DW-1:0] mem [0:2**hamster_pkg::MEM_AW-1];
  logic [hamster_pkg::MEM_AW-1:0] idx;
  logic trn;

  // Word index from byte address
  assign idx = bus.adr[hamster_pkg::MEM_AW+1:2];

  // Never stalls, never fails
  assign bus.rdy = 1'b1;
  assign bus.err = 1'b0;

  assign trn = bus.vld & bus.rdy;

  ////////////////////////////////////////////////////////////
  // Write
  ////////////////////////////////////////////////////////////

  // Per byte lane
  always_ff @(posedge bus.clk) begin
    if (trn && bus.wen) begin
      for (int i = 0; i < hamster_pkg::BW; i++) begin
        if (bus.ben[i]) begin
          mem[idx][8*i +: 8] <= bus.wdt[8*i +: 8];
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Read
  ////////////////////////////////////////////////////////////

  // Registered, zero unless a read was accepted
  always_ff @(posedge bus.clk) begin
    if (bus.rst) begin
      bus.rdt <= '0;
    end else if (trn && !bus.wen) begin
      bus.rdt <= mem[idx];
    end else begin
      bus.rdt <= '0;
    end
  end

endmodule

// File: logic/tcb_gpio.sv
// GPIO controller on TCB
// Output and enable registers, synchronized input
module tcb_gpio (
  tcb_if.sub bus,
  output logic [hamster_pkg::GW-1:0] gpio_o,
  output logic [hamster_pkg::GW-1:0] gpio_e,
  input  logic [hamster_pkg::GW-1:0] gpio_i
);

  // Two-stage input synchronizer
  logic [hamster_pkg::GW-1:0] gpio_s1;
  logic [hamster_pkg::GW-1:0] gpio_s2;
  logic [5:0] off;
  logic trn;

  assign off = bus.adr[5:0];

  // Always ready, unused offsets read zero without error
  assign bus.rdy = 1'b1;
  assign bus.err = 1'b0;

  assign trn = bus.vld & bus.rdy;

  always_ff @(posedge bus.clk) begin
    gpio_s1 <= gpio_i;
    gpio_s2 <= gpio_s1;
  end

  ////////////////////////////////////////////////////////////
  // Registers
  ////////////////////////////////////////////////////////////

  // Byte enable writes, GPIO_IN is read only
  always_ff @(posedge bus.clk) begin
    if (bus.rst) begin
      gpio_o <= '0;
      gpio_e <= '0;
    end else if (trn && bus.wen) begin
      for (int i = 0; i < hamster_pkg::BW; i++) begin
        if (bus.ben[i]) begin
          if (off == hamster_pkg::GPIO_OUT) begin
            gpio_o[8*i +: 8] <= bus.wdt[8*i +: 8];
          end
          if (off == hamster_pkg::GPIO_ENA) begin
            gpio_e[8*i +: 8] <= bus.wdt[8*i +: 8];
          end
        end
      end
    end
  end

  // Read response one cycle later
  always_ff @(posedge bus.clk) begin
    if (bus.rst) begin
      bus.rdt <= '0;
    end else if (trn && !bus.wen) begin
      case (off)
        hamster_pkg::GPIO_OUT: bus.rdt <= gpio_o;
        hamster_pkg::GPIO_ENA: bus.rdt <= gpio_e;
        hamster_pkg::GPIO_IN:  bus.rdt <= gpio_s2;
        default:               bus.rdt <= '0;
      endcase
    end else begin
      bus.rdt <= '0;
    end
  end

endmodule

// File: logic/tcb_uart_tx.sv
// UART transmitter on TCB
// Data and status registers, stall on TXD write while busy
module tcb_uart_tx (
  tcb_if.sub bus,
  output logic uart_txd
);

  hamster_pkg::uart_state_t state;
  // Cycles within a bit
  logic [hamster_pkg::UART_CW-1:0] cnt;
  // Data bit index
  logic [2:0] idx;
  // Remaining data bits, LSB goes out next
  logic [7:0] shr;
  logic [5:0] off;
  logic busy;
  logic bit_end;
  logic txd_wr;
  logic trn;

  assign off = bus.adr[5:0];
  assign busy = (state != hamster_pkg::IDLE);
  assign bit_end = (cnt == hamster_pkg::UART_CW'(hamster_pkg::UART_BDR - 1));

  // Held off until the stop bit ends
  assign bus.rdy = ~(bus.vld & bus.wen & (off == hamster_pkg::UART_TXD) & busy);
  assign bus.err = 1'b0;

  assign trn = bus.vld & bus.rdy;
  assign txd_wr = trn & bus.wen & (off == hamster_pkg::UART_TXD);

  ////////////////////////////////////////////////////////////
  // Transmit FSM
  ////////////////////////////////////////////////////////////

  // Frame starts the cycle after the accepted write
  always_ff @(posedge bus.clk) begin
    if (bus.rst) begin
      state <= hamster_pkg::IDLE;
      cnt <= '0;
      idx <= '0;
      uart_txd <= 1'b1;
    end else begin
      // Baud counter runs only inside a frame
      if (txd_wr || bit_end || !busy) begin
        cnt <= '0;
      end else begin
        cnt <= cnt + 1'b1;
      end
      case (state)
        hamster_pkg::IDLE: begin
          if (txd_wr) begin
            state <= hamster_pkg::START;
            uart_txd <= 1'b0;
          end
        end
        hamster_pkg::START: begin
          if (bit_end) begin
            state <= hamster_pkg::DATA;
            idx <= '0;
            uart_txd <= shr[0];
          end
        end
        hamster_pkg::DATA: begin
          if (bit_end) begin
            if (idx == 3'd7) begin
              state <= hamster_pkg::STOP;
              uart_txd <= 1'b1;
            end else begin
              idx <= idx + 1'b1;
              uart_txd <= shr[0];
            end
          end
        end
        default: begin
          // Stop bit
          if (bit_end) begin
            state <= hamster_pkg::IDLE;
          end
        end
      endcase
    end
  end

  // Shift register, loaded on write
  always_ff @(posedge bus.clk) begin
    if (txd_wr) begin
      shr <= bus.wdt[7:0];
    end else if (bit_end && (state != hamster_pkg::STOP)) begin
      shr <= {1'b0, shr[7:1]};
    end
  end

  ////////////////////////////////////////////////////////////
  // Read
  ////////////////////////////////////////////////////////////

  // Status bit 0 is busy, TXD reads zero
  always_ff @(posedge bus.clk) begin
    if (bus.rst) begin
      bus.rdt <= '0;
    end else if (trn && !bus.wen && (off == hamster_pkg::UART_STS)) begin
      bus.rdt <= {{(hamster_pkg::DW-1){1'b0}}, busy};
    end else begin
      bus.rdt <= '0;
    end
  end

  // Line idles high
  a_idle_high: assert property (
    @(posedge bus.clk) disable iff (bus.rst)
    (state == hamster_pkg::IDLE) |-> uart_txd
  );

endmodule

// File: tcb/tcb_arb.sv
// Round-robin arbiter, two TCB managers onto one shared bus
module tcb_arb (
  tcb_if.sub bus_cpu,
  tcb_if.sub bus_dbg,
  tcb_if.man bus_sys
);

  // Owner in this cycle
  hamster_pkg::arb_own_t own;
  // Owner of the last transfer, also tie priority
  hamster_pkg::arb_own_t own_lst;
  logic trn;

  ////////////////////////////////////////////////////////////
  // Grant
  ////////////////////////////////////////////////////////////

  // Tie goes to the manager not granted last
  always_comb begin
    if (bus_cpu.vld && bus_dbg.vld) begin
      if (own_lst == hamster_pkg::OWN_CPU) begin
        own = hamster_pkg::OWN_DBG;
      end else begin
        own = hamster_pkg::OWN_CPU;
      end
    end else if (bus_dbg.vld) begin
      own = hamster_pkg::OWN_DBG;
    end else begin
      own = hamster_pkg::OWN_CPU;
    end
  end

  // Request path, owner's signals forwarded
  assign bus_sys.vld = bus_cpu.vld | bus_dbg.vld;

  always_comb begin
    if (own == hamster_pkg::OWN_CPU) begin
      bus_sys.wen = bus_cpu.wen;
      bus_sys.adr = bus_cpu.adr;
      bus_sys.ben = bus_cpu.ben;
      bus_sys.wdt = bus_cpu.wdt;
    end else begin
      bus_sys.wen = bus_dbg.wen;
      bus_sys.adr = bus_dbg.adr;
      bus_sys.ben = bus_dbg.ben;
      bus_sys.wdt = bus_dbg.wdt;
    end
  end

  // Loser of a tie is held off
  assign bus_cpu.rdy = bus_sys.rdy & ~(bus_cpu.vld & (own == hamster_pkg::OWN_DBG));
  assign bus_dbg.rdy = bus_sys.rdy & ~(bus_dbg.vld & (own == hamster_pkg::OWN_CPU));

  assign trn = bus_sys.vld & bus_sys.rdy;

  ////////////////////////////////////////////////////////////
  // Response routing
  ////////////////////////////////////////////////////////////

  // CPU wins the first tie after reset
  always_ff @(posedge bus_sys.clk) begin
    if (bus_sys.rst) begin
      own_lst <= hamster_pkg::OWN_DBG;
    end else if (trn) begin
      own_lst <= own;
    end
  end

  // Only the owner of last cycle's transfer sees the response
  assign bus_cpu.rdt = (own_lst == hamster_pkg::OWN_CPU) ? bus_sys.rdt : '0;
  assign bus_cpu.err = (own_lst == hamster_pkg::OWN_CPU) ? bus_sys.err : 1'b0;
  assign bus_dbg.rdt = (own_lst == hamster_pkg::OWN_DBG) ? bus_sys.rdt : '0;
  assign bus_dbg.err = (own_lst == hamster_pkg::OWN_DBG) ? bus_sys.err : 1'b0;

  // Never two grants in one cycle
  a_one_grant: assert property (
    @(posedge bus_sys.clk) disable iff (bus_sys.rst)
    (bus_cpu.vld && bus_dbg.vld) |-> !(bus_cpu.rdy && bus_dbg.rdy)
  );

endmodule

// File: tcb/tcb_dec.sv
// TCB address decoder to memory, GPIO and UART
// Unmapped peripheral space answered here with an error
module tcb_dec (
  tcb_if.sub bus_sys,
  tcb_if.man bus_mem,
  tcb_if.man bus_gpio,
  tcb_if.man bus_uart
);

  hamster_pkg::tcb_sel_t sel;
  // Target of last cycle's transfer
  hamster_pkg::tcb_sel_t sel_rsp;
  logic rsp_vld;
  logic trn;

  ////////////////////////////////////////////////////////////
  // Request path
  ////////////////////////////////////////////////////////////

  // Lower half memory, GPIO and UART in the first 128 bytes above
  always_comb begin
    if (!bus_sys.adr[hamster_pkg::AW-1]) begin
      sel = hamster_pkg::SEL_MEM;
    end else if (bus_sys.adr[12:7] == '0) begin
      sel = bus_sys.adr[6] ? hamster_pkg::SEL_UART : hamster_pkg::SEL_GPIO;
    end else begin
      sel = hamster_pkg::SEL_ERR;
    end
  end

  // vld only to the selected target
  assign bus_mem.vld  = bus_sys.vld & (sel == hamster_pkg::SEL_MEM);
  assign bus_gpio.vld = bus_sys.vld & (sel == hamster_pkg::SEL_GPIO);
  assign bus_uart.vld = bus_sys.vld & (sel == hamster_pkg::SEL_UART);

  // Rest of the request broadcast
  assign bus_mem.wen  = bus_sys.wen;
  assign bus_mem.adr  = bus_sys.adr;
  assign bus_mem.ben  = bus_sys.ben;
  assign bus_mem.wdt  = bus_sys.wdt;
  assign bus_gpio.wen = bus_sys.wen;
  assign bus_gpio.adr = bus_sys.adr;
  assign bus_gpio.ben = bus_sys.ben;
  assign bus_gpio.wdt = bus_sys.wdt;
  assign bus_uart.wen = bus_sys.wen;
  assign bus_uart.adr = bus_sys.adr;
  assign bus_uart.ben = bus_sys.ben;
  assign bus_uart.wdt = bus_sys.wdt;

  // Error target always ready
  always_comb begin
    case (sel)
      hamster_pkg::SEL_MEM:  bus_sys.rdy = bus_mem.rdy;
      hamster_pkg::SEL_GPIO: bus_sys.rdy = bus_gpio.rdy;
      hamster_pkg::SEL_UART: bus_sys.rdy = bus_uart.rdy;
      default:               bus_sys.rdy = 1'b1;
    endcase
  end

  assign trn = bus_sys.vld & bus_sys.rdy;

  ////////////////////////////////////////////////////////////
  // Response path
  ////////////////////////////////////////////////////////////

  always_ff @(posedge bus_sys.clk) begin
    if (bus_sys.rst) begin
      sel_rsp <= hamster_pkg::SEL_MEM;
      rsp_vld <= 1'b0;
    end else begin
      rsp_vld <= trn;
      if (trn) begin
        sel_rsp <= sel;
      end
    end
  end

  always_comb begin
    bus_sys.rdt = '0;
    bus_sys.err = 1'b0;
    if (rsp_vld) begin
      case (sel_rsp)
        hamster_pkg::SEL_MEM: begin
          bus_sys.rdt = bus_mem.rdt;
          bus_sys.err = bus_mem.err;
        end
        hamster_pkg::SEL_GPIO: begin
          bus_sys.rdt = bus_gpio.rdt;
          bus_sys.err = bus_gpio.err;
        end
        hamster_pkg::SEL_UART: begin
          bus_sys.rdt = bus_uart.rdt;
          bus_sys.err = bus_uart.err;
        end
        // Unmapped, rdt stays zero
        default: bus_sys.err = 1'b1;
      endcase
    end
  end

  // Response routing state always known
  a_sel_known: assert property (
    @(posedge bus_sys.clk) disable iff (bus_sys.rst)
    !$isunknown(sel_rsp)
  );

endmodule

// File: test/tb_checker.sv
// Bus monitor for the SoC testbench
// Reference model, expected responses, arbitration and UART frame checks
module tb_checker (
  input logic        clk,
  input logic        rst,
  input logic        cpu_vld,
  input logic        cpu_wen,
  input logic [13:0] cpu_adr,
  input logic [3:0]  cpu_ben,
  input logic [31:0] cpu_wdt,
  input logic [31:0] cpu_rdt,
  input logic        cpu_err,
  input logic        cpu_rdy,
  input logic        dbg_vld,
  input logic        dbg_wen,
  input logic [13:0] dbg_adr,
  input logic [3:0]  dbg_ben,
  input logic [31:0] dbg_wdt,
  input logic [31:0] dbg_rdt,
  input logic        dbg_err,
  input logic        dbg_rdy,
  input logic [31:0] gpio_o,
  input logic [31:0] gpio_e,
  input logic [31:0] gpio_i,
  input logic        uart_txd
);

  // Error counters for the closing report
  int err_val = 0;
  int err_oth = 0;
  int frames_ok = 0;

  // Reference model state
  logic [31:0] mem_m [0:2047];
  logic [31:0] gpio_o_m;
  logic [31:0] gpio_e_m;
  // Cycles left in the current UART frame
  int busy_cnt;
  // Last grant went to dbg
  logic last_dbg;
  logic [7:0] frame_q [$];

  // Expected responses due one cycle after transfer
  logic cpu_pend;
  logic dbg_pend;
  logic [32:0] cpu_exp;
  logic [32:0] dbg_exp;
  // Expected handshake of a requesting port
  logic cpu_rdy_exp;
  logic dbg_rdy_exp;

  ////////////////////////////////////////////////////////////
  // Reference
  ////////////////////////////////////////////////////////////

  // Expected {err, rdt} from the address map and the model
  function automatic logic [32:0] ref_rsp(input logic wen, input logic [13:0] adr);
    logic [31:0] rdt;
    logic err;
    rdt = '0;
    err = 1'b0;
    if (!adr[13]) begin
      if (!wen) begin
        rdt = mem_m[adr[12:2]];
      end
    end else if (adr[12:7] == 6'd0) begin
      if (!wen && adr[6]) begin
        // Only the UART status reads nonzero
        if (adr[5:0] == hamster_pkg::UART_STS) begin
          rdt = {31'd0, busy_cnt != 0};
        end
      end else if (!wen) begin
        case (adr[5:0])
          hamster_pkg::GPIO_OUT: rdt = gpio_o_m;
          hamster_pkg::GPIO_ENA: rdt = gpio_e_m;
          hamster_pkg::GPIO_IN:  rdt = gpio_i;
          default:               rdt = '0;
        endcase
      end
    end else begin
      err = 1'b1;
    end
    return {err, rdt};
  endfunction

  // TXD write that the transmitter must hold off
  function automatic logic txd_held(input logic wen, input logic [13:0] adr);
    return wen && (adr == 14'h2040) && (busy_cnt != 0);
  endfunction

  // Byte-lane merge of one write into the model
  task automatic apply_write(input logic [13:0] adr, input logic [3:0] ben,
                             input logic [31:0] wdt);
    for (int i = 0; i < 4; i++) begin
      if (ben[i] && !adr[13]) begin
        mem_m[adr[12:2]][8*i +: 8] = wdt[8*i +: 8];
      end
      if (ben[i] && adr[13] && adr[12:6] == 7'd0 && adr[5:0] == hamster_pkg::GPIO_OUT) begin
        gpio_o_m[8*i +: 8] = wdt[8*i +: 8];
      end
      if (ben[i] && adr[13] && adr[12:6] == 7'd0 && adr[5:0] == hamster_pkg::GPIO_ENA) begin
        gpio_e_m[8*i +: 8] = wdt[8*i +: 8];
      end
    end
  endtask

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      $display("error: %s expected %h actual %h at %0t", name, exp, act, $time);
      err_val++;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Compare process
  ////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    if (rst) begin
      cpu_pend = 1'b0;
      dbg_pend = 1'b0;
      gpio_o_m = '0;
      gpio_e_m = '0;
      busy_cnt = 0;
      last_dbg = 1'b1;
    end else begin
      // Responses of last cycle's transfers and zero on the other port
      check_val("cpu_rdt", cpu_pend ? cpu_exp[31:0] : 32'd0, cpu_rdt);
      check_val("cpu_err", {31'd0, cpu_pend & cpu_exp[32]}, {31'd0, cpu_err});
      check_val("dbg_rdt", dbg_pend ? dbg_exp[31:0] : 32'd0, dbg_rdt);
      check_val("dbg_err", {31'd0, dbg_pend & dbg_exp[32]}, {31'd0, dbg_err});
      // GPIO outputs follow from the cycle after the write
      check_val("gpio_o", gpio_o_m, gpio_o);
      check_val("gpio_e", gpio_e_m, gpio_e);

      // Tie loser and a TXD write during a frame see rdy low
      cpu_rdy_exp = (!dbg_vld || last_dbg) && !txd_held(cpu_wen, cpu_adr);
      dbg_rdy_exp = (!cpu_vld || !last_dbg) && !txd_held(dbg_wen, dbg_adr);
      if (cpu_vld) begin
        check_val("cpu_rdy", {31'd0, cpu_rdy_exp}, {31'd0, cpu_rdy});
      end
      if (dbg_vld) begin
        check_val("dbg_rdy", {31'd0, dbg_rdy_exp}, {31'd0, dbg_rdy});
      end

      cpu_pend = cpu_vld && cpu_rdy;
      dbg_pend = dbg_vld && dbg_rdy;
      cpu_exp = ref_rsp(cpu_wen, cpu_adr);
      dbg_exp = ref_rsp(dbg_wen, dbg_adr);

      if (busy_cnt != 0) begin
        busy_cnt--;
      end

      if (cpu_pend) begin
        last_dbg = 1'b0;
        if (cpu_wen) begin
          apply_write(cpu_adr, cpu_ben, cpu_wdt);
          if (cpu_adr == 14'h2040) begin
            frame_q.push_back(cpu_wdt[7:0]);
            busy_cnt = 10 * hamster_pkg::UART_BDR;
          end
        end
      end
      if (dbg_pend) begin
        last_dbg = 1'b1;
        if (dbg_wen) begin
          apply_write(dbg_adr, dbg_ben, dbg_wdt);
          if (dbg_adr == 14'h2040) begin
            frame_q.push_back(dbg_wdt[7:0]);
            busy_cnt = 10 * hamster_pkg::UART_BDR;
          end
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // UART frame decoding
  ////////////////////////////////////////////////////////////

  // Sample each bit in its middle
  always begin
    logic [7:0] rx;
    @(negedge uart_txd);
    repeat (hamster_pkg::UART_BDR / 2) @(posedge clk);
    if (uart_txd !== 1'b0) begin
      $display("UART start bit not held low at %0t", $time);
      err_oth++;
    end
    for (int b = 0; b < 8; b++) begin
      repeat (hamster_pkg::UART_BDR) @(posedge clk);
      rx[b] = uart_txd;
    end
    repeat (hamster_pkg::UART_BDR) @(posedge clk);
    if (uart_txd !== 1'b1) begin
      $display("UART stop bit missing at %0t", $time);
      err_oth++;
    end
    if (frame_q.size() == 0) begin
      $display("UART frame sent without a data write at %0t", $time);
      err_oth++;
    end else begin
      check_val("uart_txd frame", {24'd0, frame_q.pop_front()}, {24'd0, rx});
      frames_ok++;
    end
  end

  // Frames written but never seen on the line
  task automatic check_frames();
    if (frame_q.size() != 0) begin
      $display("%0d UART frames were written but not transmitted", frame_q.size());
      err_oth++;
    end
  endtask

endmodule

// File: test/tb_hamster_soc.sv
// Testbench top for the SoC bus subsystem
// Clock, reset, stimulus on both manager ports, watchdog and report
module tb_hamster_soc;

  // Rough length of all tests in cycles with frames included
  localparam int TEST_CYC = 4 + 2 * 48 + 20 + 40 + 2 * 80 + 60 + 20;
  localparam int WDOG_TIME = TEST_CYC * 10 * 4;

  logic        clk;
  logic        rst;
  logic        cpu_vld;
  logic        cpu_wen;
  logic [13:0] cpu_adr;
  logic [3:0]  cpu_ben;
  logic [31:0] cpu_wdt;
  logic [31:0] cpu_rdt;
  logic        cpu_err;
  logic        cpu_rdy;
  logic        dbg_vld;
  logic        dbg_wen;
  logic [13:0] dbg_adr;
  logic [3:0]  dbg_ben;
  logic [31:0] dbg_wdt;
  logic [31:0] dbg_rdt;
  logic        dbg_err;
  logic        dbg_rdy;
  logic [31:0] gpio_o;
  logic [31:0] gpio_e;
  logic [31:0] gpio_i;
  logic        uart_txd;

  hamster_soc_top DUT (.*);

  tb_checker chk (.*);

  always #5 clk = ~clk;

  ////////////////////////////////////////////////////////////
  // Port drivers
  ////////////////////////////////////////////////////////////

  // Starts at a falling edge and returns at the falling edge after the transfer
  task automatic cpu_req(input logic wen, input logic [13:0] adr, input logic [3:0] ben,
                         input logic [31:0] wdt);
    cpu_vld = 1'b1;
    cpu_wen = wen;
    cpu_adr = adr;
    cpu_ben = ben;
    cpu_wdt = wdt;
    @(posedge clk);
    while (!cpu_rdy) @(posedge clk);
    @(negedge clk);
  endtask

  task automatic dbg_req(input logic wen, input logic [13:0] adr, input logic [3:0] ben,
                         input logic [31:0] wdt);
    dbg_vld = 1'b1;
    dbg_wen = wen;
    dbg_adr = adr;
    dbg_ben = ben;
    dbg_wdt = wdt;
    @(posedge clk);
    while (!dbg_rdy) @(posedge clk);
    @(negedge clk);
  endtask

  ////////////////////////////////////////////////////////////
  // Sequences
  ////////////////////////////////////////////////////////////

  // Full writes, random byte-enable writes, then reads of a word range
  task automatic cpu_mem_seq(input int base);
    for (int w = 0; w < 16; w++) begin
      cpu_req(1'b1, 14'(base + w) << 2, 4'hf, $urandom);
    end
    for (int n = 0; n < 16; n++) begin
      cpu_req(1'b1, 14'(base + $urandom_range(15)) << 2, 4'($urandom), $urandom);
    end
    for (int w = 0; w < 16; w++) begin
      cpu_req(1'b0, 14'(base + w) << 2, 4'hf, 32'd0);
    end
    cpu_vld = 1'b0;
  endtask

  task automatic dbg_mem_seq(input int base);
    for (int w = 0; w < 16; w++) begin
      dbg_req(1'b1, 14'(base + w) << 2, 4'hf, $urandom);
    end
    for (int n = 0; n < 16; n++) begin
      dbg_req(1'b1, 14'(base + $urandom_range(15)) << 2, 4'($urandom), $urandom);
    end
    for (int w = 0; w < 16; w++) begin
      dbg_req(1'b0, 14'(base + w) << 2, 4'hf, 32'd0);
    end
    dbg_vld = 1'b0;
  endtask

  // GPIO outputs, enables and input synchronizer
  task automatic cpu_gpio_seq();
    cpu_req(1'b1, 14'h2000, 4'hf, $urandom);
    cpu_req(1'b1, 14'h2004, 4'($urandom), $urandom);
    cpu_req(1'b1, 14'h2000, 4'($urandom), $urandom);
    cpu_req(1'b0, 14'h2000, 4'hf, 32'd0);
    cpu_req(1'b0, 14'h2004, 4'hf, 32'd0);
    cpu_vld = 1'b0;
    gpio_i = $urandom;
    repeat (4) @(negedge clk);
    cpu_req(1'b1, 14'h2008, 4'hf, $urandom);
    cpu_req(1'b0, 14'h2008, 4'hf, 32'd0);
    cpu_req(1'b0, 14'h200c, 4'hf, 32'd0);
    cpu_vld = 1'b0;
  endtask

  // Two frames with the second write held until the first ends
  task automatic cpu_uart_seq();
    logic [31:0] sts;
    cpu_req(1'b1, 14'h2040, 4'h1, {24'd0, 8'($urandom)});
    cpu_req(1'b0, 14'h2044, 4'hf, 32'd0);
    cpu_req(1'b1, 14'h2040, 4'h1, {24'd0, 8'($urandom)});
    do begin
      cpu_req(1'b0, 14'h2044, 4'hf, 32'd0);
      sts = cpu_rdt;
    end while (sts[0]);
    cpu_vld = 1'b0;
  endtask

  // Unmapped accesses followed by memory and GPIO read back
  task automatic dbg_err_seq();
    dbg_req(1'b1, 14'h2080, 4'hf, $urandom);
    dbg_req(1'b0, 14'h2080, 4'hf, 32'd0);
    dbg_req(1'b1, 14'h3ffc, 4'hf, $urandom);
    dbg_req(1'b0, 14'h3ffc, 4'hf, 32'd0);
    dbg_req(1'b0, 14'h0040, 4'hf, 32'd0);
    dbg_req(1'b0, 14'h2000, 4'hf, 32'd0);
    dbg_req(1'b0, 14'h2004, 4'hf, 32'd0);
    dbg_vld = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////
  // Main
  ////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(32'h72f6));
    clk = 1'b0;
    rst = 1'b1;
    {cpu_vld, cpu_wen, cpu_adr, cpu_ben, cpu_wdt} = '0;
    {dbg_vld, dbg_wen, dbg_adr, dbg_ben, dbg_wdt} = '0;
    gpio_i = '0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    fork
      cpu_mem_seq(0);
      dbg_mem_seq(16);
    join
    // Burst with both ports holding vld
    fork
      for (int w = 0; w < 8; w++) begin
        cpu_req(1'b0, 14'(w) << 2, 4'hf, 32'd0);
      end
      for (int w = 0; w < 8; w++) begin
        dbg_req(1'b0, 14'(16 + w) << 2, 4'hf, 32'd0);
      end
    join
    cpu_vld = 1'b0;
    dbg_vld = 1'b0;
    cpu_gpio_seq();
    cpu_uart_seq();
    dbg_err_seq();
    repeat (4) @(negedge clk);

    chk.check_frames();
    $display("errors: %0d value, %0d other, %0d frames checked",
             chk.err_val, chk.err_oth, chk.frames_ok);
    if (chk.err_val + chk.err_oth == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(WDOG_TIME);
    $display("watchdog expired before the tests finished");
    $display("errors: %0d value, %0d other", chk.err_val, chk.err_oth);
    $display("Simulation failed");
    $finish;
  end

endmodule
